// File: rtl/lc3b_cfg.svh
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

`define LC3B_WORD_W     16
`define LC3B_NREG       8
`define LC3B_DMEM_AW    8        // word addressed, byte address bit 0 is dropped

`define LC3B_PC_RESET   16'h3000

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opcodes of the supported subset
`define LC3B_OP_ADD     4'b0001
`define LC3B_OP_AND     4'b0101
`define LC3B_OP_NOT     4'b1001
`define LC3B_OP_SHF     4'b1101
`define LC3B_OP_LEA     4'b1110
`define LC3B_OP_LDR     4'b0110
`define LC3B_OP_STR     4'b0111
`define LC3B_OP_LDI     4'b1010
`define LC3B_OP_STI     4'b1011

`endif

// File: rtl/lc3b_pkg.sv
`include "lc3b_cfg.svh"

package lc3b_pkg;

// the same instruction word seen as an operate format or a memory format
typedef union packed {
    struct packed {
        logic [3:0] opcode;
        logic [2:0] dr;
        logic [2:0] sr1;
        logic       imm;          // for SHF this is the arithmetic flag
        logic [4:0] tail;         // sr2 in the low bits, imm5, or SHF direction and count
    } opr;
    struct packed {
        logic [3:0] opcode;
        logic [2:0] dr;           // store data register for STR and STI
        logic [2:0] base;
        logic [5:0] offset6;
    } mem;
} lc3b_instr_t;

// nzp code of a value written to the register file
function automatic logic [2:0] lc3b_nzp(input logic [`LC3B_WORD_W-1:0] value);
    logic [2:0] cc;

    if (value[`LC3B_WORD_W-1])
        cc = 3'b100;
    else if (value == '0)
        cc = 3'b010;
    else
        cc = 3'b001;
    return cc;
endfunction

endpackage : lc3b_pkg

// File: rtl/lc3b_regfile.sv
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module lc3b_regfile
(
    input  logic                            clk,
    input  logic                            rst,

    input  logic [$clog2(`LC3B_NREG)-1:0]   rd_addr1,
    input  logic [$clog2(`LC3B_NREG)-1:0]   rd_addr2,
    output logic [`LC3B_WORD_W-1:0]         rd_data1,
    output logic [`LC3B_WORD_W-1:0]         rd_data2,

    input  logic                            wr_en,
    input  logic [$clog2(`LC3B_NREG)-1:0]   wr_addr,
    input  logic [`LC3B_WORD_W-1:0]         wr_data
);

logic [`LC3B_WORD_W-1:0] regs [`LC3B_NREG];

always_ff @(posedge clk)
begin
    if (rst)
    begin
        for (int i = 0; i < `LC3B_NREG; i++)
            regs[i] <= '0;
    end
    else if (wr_en)
        regs[wr_addr] <= wr_data;
end

// reads see the value written on the previous edge
assign rd_data1 = regs[rd_addr1];
assign rd_data2 = regs[rd_addr2];

endmodule : lc3b_regfile

// File: rtl/lc3b_decode.sv
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module lc3b_decode
(
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        instr_valid,
    input  logic [`LC3B_WORD_W-1:0]     instr,
    output logic                        instr_ready,

    output logic [2:0]                  rd_addr1,
    output logic [2:0]                  rd_addr2,
    input  logic [`LC3B_WORD_W-1:0]     rd_data1,
    input  logic [`LC3B_WORD_W-1:0]     rd_data2,

    input  logic                        ex_stall,
    input  logic                        ex_valid,
    input  logic [2:0]                  ex_dr,
    input  logic                        ex_load_regfile,
    input  logic                        mem_hz_valid,
    input  logic [2:0]                  mem_hz_dr,
    input  logic                        mem_hz_load,

    output logic                        de_valid,
    output lc3b_pkg::lc3b_instr_t       de_instr,
    output logic [`LC3B_WORD_W-1:0]     de_npc,
    output logic [`LC3B_WORD_W-1:0]     de_sr1_val,
    output logic [`LC3B_WORD_W-1:0]     de_sr2_val,
    output logic                        de_load_regfile,
    output logic                        de_load_cc,
    output logic                        de_mem_read,
    output logic                        de_mem_write,
    output logic                        de_indirect,
    output logic                        de_addr_sel,
    output logic                        de_use_imm
);

logic [`LC3B_WORD_W-1:0] pc;
logic d_valid;
logic sr1_used;
logic sr2_used;
logic src1_hit;
logic src2_hit;
logic dep_stall;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// intake and decode register

always_ff @(posedge clk)
begin
    if (rst)
    begin
        pc <= `LC3B_PC_RESET;
        d_valid <= 1'b0;
    end
    else if (instr_ready)
    begin
        d_valid <= instr_valid;                 // a bubble when nothing is offered
        if (instr_valid)
            pc <= pc + 16'd2;
    end
end

always_ff @(posedge clk)
begin
    if (instr_ready && instr_valid)
    begin
        de_instr <= instr;
        de_npc <= pc + 16'd2;
    end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control decode

assign rd_addr1 = de_instr.opr.sr1;             // also the base register of loads and stores

always_comb
begin
    de_load_regfile = 1'b0;
    de_load_cc = 1'b0;
    de_mem_read = 1'b0;
    de_mem_write = 1'b0;
    de_indirect = 1'b0;
    de_addr_sel = 1'b0;
    de_use_imm = 1'b0;
    sr1_used = 1'b0;
    sr2_used = 1'b0;
    rd_addr2 = de_instr.opr.tail[2:0];

    case (de_instr.opr.opcode)
        `LC3B_OP_ADD, `LC3B_OP_AND:
        begin
            de_load_regfile = 1'b1;
            de_load_cc = 1'b1;
            de_use_imm = de_instr.opr.imm;
            sr1_used = 1'b1;
            sr2_used = !de_instr.opr.imm;
        end
        `LC3B_OP_NOT, `LC3B_OP_SHF:
        begin
            de_load_regfile = 1'b1;
            de_load_cc = 1'b1;
            sr1_used = 1'b1;
        end
        `LC3B_OP_LEA:
            de_load_regfile = 1'b1;             // npc relative, condition codes untouched
        `LC3B_OP_LDR, `LC3B_OP_LDI:
        begin
            de_load_regfile = 1'b1;
            de_load_cc = 1'b1;
            de_mem_read = 1'b1;
            de_indirect = (de_instr.mem.opcode == `LC3B_OP_LDI);
            de_addr_sel = 1'b1;
            sr1_used = 1'b1;
        end
        `LC3B_OP_STR, `LC3B_OP_STI:
        begin
            de_mem_write = 1'b1;
            de_indirect = (de_instr.mem.opcode == `LC3B_OP_STI);
            de_addr_sel = 1'b1;
            sr1_used = 1'b1;
            sr2_used = 1'b1;
            rd_addr2 = de_instr.mem.dr;
        end
        default: ;
    endcase
end

assign de_sr1_val = rd_data1;
assign de_sr2_val = rd_data2;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dependency stall against writers still in execute and memory

assign src1_hit = (ex_valid && ex_load_regfile && ex_dr == rd_addr1)
               || (mem_hz_valid && mem_hz_load && mem_hz_dr == rd_addr1);
assign src2_hit = (ex_valid && ex_load_regfile && ex_dr == rd_addr2)
               || (mem_hz_valid && mem_hz_load && mem_hz_dr == rd_addr2);

assign dep_stall = d_valid && ((sr1_used && src1_hit) || (sr2_used && src2_hit));

assign de_valid = d_valid && !dep_stall;        // execute sees a bubble while we wait
assign instr_ready = !(dep_stall || ex_stall);

a_supported_op: assert property (@(posedge clk) disable iff (rst)
    de_valid |-> de_instr.opr.opcode inside {`LC3B_OP_ADD, `LC3B_OP_AND, `LC3B_OP_NOT,
                                             `LC3B_OP_SHF, `LC3B_OP_LEA, `LC3B_OP_LDR,
                                             `LC3B_OP_STR, `LC3B_OP_LDI, `LC3B_OP_STI});

endmodule : lc3b_decode

// File: rtl/lc3b_execute.sv
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module lc3b_execute
(
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        de_valid,
    input  lc3b_pkg::lc3b_instr_t       de_instr,
    input  logic [`LC3B_WORD_W-1:0]     de_npc,
    input  logic [`LC3B_WORD_W-1:0]     de_sr1_val,
    input  logic [`LC3B_WORD_W-1:0]     de_sr2_val,
    input  logic                        de_load_regfile,
    input  logic                        de_load_cc,
    input  logic                        de_mem_read,
    input  logic                        de_mem_write,
    input  logic                        de_indirect,
    input  logic                        de_addr_sel,
    input  logic                        de_use_imm,

    input  logic                        mem_stall,
    output logic                        ex_stall,

    output logic                        ex_valid,
    output logic [2:0]                  ex_dr,
    output logic [`LC3B_WORD_W-1:0]     ex_result,
    output logic [`LC3B_WORD_W-1:0]     ex_address,
    output logic [`LC3B_WORD_W-1:0]     ex_store_data,
    output logic                        ex_load_regfile,
    output logic                        ex_load_cc,
    output logic                        ex_mem_read,
    output logic                        ex_mem_write,
    output logic                        ex_indirect
);

logic [`LC3B_WORD_W-1:0] imm5_sext;
logic [`LC3B_WORD_W-1:0] off6_adj;
logic [`LC3B_WORD_W-1:0] off9_adj;
logic [`LC3B_WORD_W-1:0] addr_base;
logic [`LC3B_WORD_W-1:0] addr_off;
logic [`LC3B_WORD_W-1:0] adder_out;
logic [`LC3B_WORD_W-1:0] alu_b;
logic [`LC3B_WORD_W-1:0] alu_out;
logic [3:0] shf_count;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand and address formation

assign imm5_sext = {{(`LC3B_WORD_W-5){de_instr.opr.tail[4]}}, de_instr.opr.tail};
assign off6_adj = {{(`LC3B_WORD_W-7){de_instr.mem.offset6[5]}}, de_instr.mem.offset6, 1'b0};
assign off9_adj = {{(`LC3B_WORD_W-10){de_instr[8]}}, de_instr[8:0], 1'b0};

assign addr_base = de_addr_sel ? de_sr1_val : de_npc;
assign addr_off = de_addr_sel ? off6_adj : off9_adj;
assign adder_out = addr_base + addr_off;

assign alu_b = de_use_imm ? imm5_sext : de_sr2_val;
assign shf_count = de_instr.opr.tail[3:0];

always_comb
begin
    case (de_instr.opr.opcode)
        `LC3B_OP_ADD: alu_out = de_sr1_val + alu_b;
        `LC3B_OP_AND: alu_out = de_sr1_val & alu_b;
        `LC3B_OP_NOT: alu_out = ~de_sr1_val;
        `LC3B_OP_SHF:
        begin
            if (!de_instr.opr.tail[4])
                alu_out = de_sr1_val << shf_count;
            else if (!de_instr.opr.imm)
                alu_out = de_sr1_val >> shf_count;
            else
                alu_out = $signed(de_sr1_val) >>> shf_count;
        end
        default: alu_out = adder_out;           // LEA result; loads replace it with memory data
    endcase
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute/memory register

// LDI and STI leave here in their LDR/STR form, with ex_indirect asking the
// memory stage to fetch the pointer before the direct access
always_ff @(posedge clk)
begin
    if (rst)
    begin
        ex_valid <= 1'b0;
        ex_load_regfile <= 1'b0;
        ex_load_cc <= 1'b0;
        ex_mem_read <= 1'b0;
        ex_mem_write <= 1'b0;
        ex_indirect <= 1'b0;
    end
    else if (!mem_stall)
    begin
        ex_valid <= de_valid;
        ex_load_regfile <= de_valid && de_load_regfile;
        ex_load_cc <= de_valid && de_load_cc;
        ex_mem_read <= de_valid && de_mem_read;
        ex_mem_write <= de_valid && de_mem_write;
        ex_indirect <= de_valid && de_indirect;
    end
end

always_ff @(posedge clk)
begin
    if (!mem_stall)
    begin
        ex_dr <= de_instr.opr.dr;
        ex_result <= alu_out;
        ex_address <= adder_out;
        ex_store_data <= de_sr2_val;
    end
end

assign ex_stall = mem_stall;                    // decode freezes with us

endmodule : lc3b_execute

// File: rtl/lc3b_mem_stage.sv
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module lc3b_mem_stage
(
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        ex_valid,
    input  logic [2:0]                  ex_dr,
    input  logic [`LC3B_WORD_W-1:0]     ex_result,
    input  logic [`LC3B_WORD_W-1:0]     ex_address,
    input  logic [`LC3B_WORD_W-1:0]     ex_store_data,
    input  logic                        ex_load_regfile,
    input  logic                        ex_load_cc,
    input  logic                        ex_mem_read,
    input  logic                        ex_mem_write,
    input  logic                        ex_indirect,

    output logic                        mem_stall,
    output logic                        mem_hz_valid,
    output logic [2:0]                  mem_hz_dr,
    output logic                        mem_hz_load,

    output logic                        rf_wr_en,
    output logic [2:0]                  rf_wr_addr,
    output logic [`LC3B_WORD_W-1:0]     rf_wr_data,

    output logic                        wb_valid,
    output logic [2:0]                  wb_dr,
    output logic [`LC3B_WORD_W-1:0]     wb_data,
    output logic [2:0]                  wb_cc
);

import lc3b_pkg::*;

logic m_valid;
logic m_load_regfile;
logic m_load_cc;
logic m_mem_read;
logic m_mem_write;
logic m_indirect;
logic [2:0] m_dr;
logic [`LC3B_WORD_W-1:0] m_result;
logic [`LC3B_WORD_W-1:0] m_address;
logic [`LC3B_WORD_W-1:0] m_store_data;

logic [`LC3B_WORD_W-1:0] dmem [2**`LC3B_DMEM_AW];
logic [`LC3B_DMEM_AW-1:0] word_addr;
logic [`LC3B_WORD_W-1:0] rd_word;
logic commit;

always_ff @(posedge clk)
begin
    if (rst)
    begin
        m_valid <= 1'b0;
        m_load_regfile <= 1'b0;
        m_load_cc <= 1'b0;
        m_mem_read <= 1'b0;
        m_mem_write <= 1'b0;
        m_indirect <= 1'b0;
    end
    else if (mem_stall)
        m_indirect <= 1'b0;                     // pointer is in hand so the direct access comes next
    else
    begin
        m_valid <= ex_valid;
        m_load_regfile <= ex_load_regfile;
        m_load_cc <= ex_load_cc;
        m_mem_read <= ex_mem_read;
        m_mem_write <= ex_mem_write;
        m_indirect <= ex_indirect;
    end
end

always_ff @(posedge clk)
begin
    if (mem_stall)
        m_address <= rd_word;                   // first access of LDI/STI fetched the pointer
    else
    begin
        m_dr <= ex_dr;
        m_result <= ex_result;
        m_address <= ex_address;
        m_store_data <= ex_store_data;
    end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data memory

assign word_addr = m_address[`LC3B_DMEM_AW:1];
assign rd_word = dmem[word_addr];
assign mem_stall = m_valid && m_indirect;

always_ff @(posedge clk)
begin
    if (m_mem_write && !mem_stall)
        dmem[word_addr] <= m_store_data;
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// commit

assign commit = m_load_regfile && !mem_stall;
assign rf_wr_en = commit;                       // lands with the rise of wb_valid
assign rf_wr_addr = m_dr;
assign rf_wr_data = m_mem_read ? rd_word : m_result;

always_ff @(posedge clk)
begin
    if (rst)
    begin
        wb_valid <= 1'b0;
        wb_cc <= 3'b010;
    end
    else
    begin
        wb_valid <= commit;
        if (commit && m_load_cc)
            wb_cc <= lc3b_nzp(rf_wr_data);
    end
end

always_ff @(posedge clk)
begin
    if (commit)
    begin
        wb_dr <= m_dr;
        wb_data <= rf_wr_data;
    end
end

assign mem_hz_valid = m_valid;
assign mem_hz_dr = m_dr;
assign mem_hz_load = m_load_regfile;

a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst)
    ex_valid |-> !(ex_mem_read && ex_mem_write));

// only a load or a store ever fetches a pointer
a_stall_mem_op: assert property (@(posedge clk) disable iff (rst)
    mem_stall |-> (m_mem_read || m_mem_write));

endmodule : lc3b_mem_stage

// File: rtl/lc3b_core.sv
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module lc3b_core
(
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        instr_valid,
    input  logic [`LC3B_WORD_W-1:0]     instr,
    output logic                        instr_ready,

    output logic                        wb_valid,
    output logic [2:0]                  wb_dr,
    output logic [`LC3B_WORD_W-1:0]     wb_data,
    output logic [2:0]                  wb_cc
);

logic [2:0] rd_addr1;
logic [2:0] rd_addr2;
logic [`LC3B_WORD_W-1:0] rd_data1;
logic [`LC3B_WORD_W-1:0] rd_data2;
logic rf_wr_en;
logic [2:0] rf_wr_addr;
logic [`LC3B_WORD_W-1:0] rf_wr_data;

// decode to execute
logic de_valid;
logic [`LC3B_WORD_W-1:0] de_instr;
logic [`LC3B_WORD_W-1:0] de_npc;
logic [`LC3B_WORD_W-1:0] de_sr1_val;
logic [`LC3B_WORD_W-1:0] de_sr2_val;
logic de_load_regfile;
logic de_load_cc;
logic de_mem_read;
logic de_mem_write;
logic de_indirect;
logic de_addr_sel;
logic de_use_imm;
logic ex_stall;

// execute to memory
logic ex_valid;
logic [2:0] ex_dr;
logic [`LC3B_WORD_W-1:0] ex_result;
logic [`LC3B_WORD_W-1:0] ex_address;
logic [`LC3B_WORD_W-1:0] ex_store_data;
logic ex_load_regfile;
logic ex_load_cc;
logic ex_mem_read;
logic ex_mem_write;
logic ex_indirect;
logic mem_stall;
logic mem_hz_valid;
logic [2:0] mem_hz_dr;
logic mem_hz_load;

lc3b_decode lc3b_decode_i
(
    .clk, .rst,
    .instr_valid, .instr, .instr_ready,
    .rd_addr1, .rd_addr2, .rd_data1, .rd_data2,
    .ex_stall, .ex_valid, .ex_dr, .ex_load_regfile,
    .mem_hz_valid, .mem_hz_dr, .mem_hz_load,
    .de_valid, .de_instr (de_instr), .de_npc, .de_sr1_val, .de_sr2_val,
    .de_load_regfile, .de_load_cc, .de_mem_read, .de_mem_write,
    .de_indirect, .de_addr_sel, .de_use_imm
);

lc3b_regfile lc3b_regfile_i
(
    .clk, .rst,
    .rd_addr1, .rd_addr2, .rd_data1, .rd_data2,
    .wr_en   (rf_wr_en),
    .wr_addr (rf_wr_addr),
    .wr_data (rf_wr_data)
);

lc3b_execute lc3b_execute_i
(
    .clk, .rst,
    .de_valid, .de_instr (de_instr), .de_npc, .de_sr1_val, .de_sr2_val,
    .de_load_regfile, .de_load_cc, .de_mem_read, .de_mem_write,
    .de_indirect, .de_addr_sel, .de_use_imm,
    .mem_stall, .ex_stall,
    .ex_valid, .ex_dr, .ex_result, .ex_address, .ex_store_data,
    .ex_load_regfile, .ex_load_cc, .ex_mem_read, .ex_mem_write, .ex_indirect
);

lc3b_mem_stage lc3b_mem_stage_i
(
    .clk, .rst,
    .ex_valid, .ex_dr, .ex_result, .ex_address, .ex_store_data,
    .ex_load_regfile, .ex_load_cc, .ex_mem_read, .ex_mem_write, .ex_indirect,
    .mem_stall, .mem_hz_valid, .mem_hz_dr, .mem_hz_load,
    .rf_wr_en, .rf_wr_addr, .rf_wr_data,
    .wb_valid, .wb_dr, .wb_data, .wb_cc
);

endmodule : lc3b_core

// File: verif/lc3b_core_tb.sv
`timescale 1ns/10ps
`include "lc3b_cfg.svh"

module lc3b_core_tb;

localparam int N_ALU = 40;
localparam int N_SHF = 24;
localparam int N_LEA = 8;
localparam int N_LDST = 24;
localparam int N_IND = 36;
localparam int N_RAND = 300;
localparam int N_TOTAL = N_ALU + N_SHF + N_LEA + N_LDST + N_IND + N_RAND;
localparam int CYCLE_LIMIT = 5 * N_TOTAL + 200;
localparam int DRAIN_LIMIT = 20;                // three in flight with one of them indirect

logic clk;
logic rst;
logic instr_valid;
logic [`LC3B_WORD_W-1:0] instr;
logic instr_ready;
logic wb_valid;
logic [2:0] wb_dr;
logic [`LC3B_WORD_W-1:0] wb_data;
logic [2:0] wb_cc;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference state updated in program order at acceptance

logic [`LC3B_WORD_W-1:0] model_reg [`LC3B_NREG];
logic [`LC3B_WORD_W-1:0] model_mem [2**`LC3B_DMEM_AW];
logic model_mem_ok [2**`LC3B_DMEM_AW];          // word has been stored to
logic [`LC3B_WORD_W-1:0] model_pc;
logic [2:0] model_cc;
logic [21:0] expect_q [$];                      // {dr, data, cc} per register write

logic [31:0] rng_state = 32'd76524;
logic ready_sampled;
string test_name = "reset";
int error_count = 0;
int commit_count = 0;
int issue_count = 0;
int test_count = 0;
int cycle_count = 0;
int errors_at_start;
int commits_at_start;
int issues_at_start;

lc3b_core lc3b_core_i
(
    .clk, .rst,
    .instr_valid, .instr, .instr_ready,
    .wb_valid, .wb_dr, .wb_data, .wb_cc
);

initial
begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

function automatic logic [31:0] xorshift();
    logic [31:0] x;

    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic logic [15:0] opr_word(input logic [3:0] op, input logic [2:0] dr,
                                         input logic [2:0] sr1, input logic imm,
                                         input logic [4:0] tail);
    return {op, dr, sr1, imm, tail};
endfunction

function automatic logic [15:0] mem_word(input logic [3:0] op, input logic [2:0] dr,
                                         input logic [2:0] base, input logic [5:0] off6);
    return {op, dr, base, off6};
endfunction

function automatic logic [15:0] lea_word(input logic [2:0] dr, input logic [8:0] off9);
    return {`LC3B_OP_LEA, dr, off9};
endfunction

function automatic logic [2:0] cc_of(input logic [15:0] value);
    if (value[15])
        return 3'b100;
    else if (value == 16'd0)
        return 3'b010;
    return 3'b001;
endfunction

// shifts one bit position per step with kind as {arithmetic, right}
function automatic logic [15:0] shift_value(input logic [15:0] value, input logic [1:0] kind,
                                            input logic [3:0] count);
    logic [15:0] result;

    result = value;
    for (int i = 0; i < count; i++)
    begin
        if (!kind[0])
            result = {result[14:0], 1'b0};
        else if (!kind[1])
            result = {1'b0, result[15:1]};
        else
            result = {result[15], result[15:1]};
    end
    return result;
endfunction

function automatic void clear_model();
    for (int i = 0; i < `LC3B_NREG; i++)
        model_reg[i] = '0;
    for (int i = 0; i < 2**`LC3B_DMEM_AW; i++)
    begin
        model_mem[i] = '0;
        model_mem_ok[i] = 1'b0;
    end
    model_pc = `LC3B_PC_RESET;
    model_cc = 3'b010;
endfunction

function automatic void model_execute(input logic [15:0] word);
    logic [2:0] dr;
    logic [15:0] sr1_val;
    logic [15:0] operand;
    logic [15:0] addr;
    logic [15:0] ptr;
    logic [15:0] result;
    logic writes;
    logic sets_cc;

    dr = word[11:9];
    sr1_val = model_reg[word[8:6]];
    operand = word[5] ? {{11{word[4]}}, word[4:0]} : model_reg[word[2:0]];
    addr = sr1_val + {{9{word[5]}}, word[5:0], 1'b0};
    ptr = model_mem[addr[`LC3B_DMEM_AW:1]];
    result = '0;
    writes = 1'b1;
    sets_cc = 1'b1;

    case (word[15:12])
        `LC3B_OP_ADD: result = sr1_val + operand;
        `LC3B_OP_AND: result = sr1_val & operand;
        `LC3B_OP_NOT: result = ~sr1_val;
        `LC3B_OP_SHF: result = shift_value(sr1_val, word[5:4], word[3:0]);
        `LC3B_OP_LEA:
        begin
            result = model_pc + 16'd2 + {{6{word[8]}}, word[8:0], 1'b0};
            sets_cc = 1'b0;
        end
        `LC3B_OP_LDR: result = model_mem[addr[`LC3B_DMEM_AW:1]];
        `LC3B_OP_LDI: result = model_mem[ptr[`LC3B_DMEM_AW:1]];
        `LC3B_OP_STR:
        begin
            model_mem[addr[`LC3B_DMEM_AW:1]] = model_reg[dr];
            model_mem_ok[addr[`LC3B_DMEM_AW:1]] = 1'b1;
            writes = 1'b0;
        end
        `LC3B_OP_STI:
        begin
            model_mem[ptr[`LC3B_DMEM_AW:1]] = model_reg[dr];
            model_mem_ok[ptr[`LC3B_DMEM_AW:1]] = 1'b1;
            writes = 1'b0;
        end
        default: writes = 1'b0;
    endcase

    if (writes)
    begin
        model_reg[dr] = result;
        if (sets_cc)
            model_cc = cc_of(result);
        expect_q.push_back({dr, result, model_cc});
    end
    model_pc = model_pc + 16'd2;
endfunction

// selector 0..4 ALU, 5 SHF, 6 LEA, 7 LDR, 8 STR
function automatic logic [15:0] random_instr(input logic [2:0] last_dr, input int first,
                                             input int kinds);
    logic [31:0] r;
    logic [2:0] dr;
    logic [2:0] sr1;
    logic [2:0] sr2;
    logic [1:0] kind;
    logic [15:0] addr;
    logic [15:0] word;
    int sel;

    r = xorshift();
    dr = r[2:0];
    sr1 = r[3] ? last_dr : r[6:4];
    sr2 = r[7] ? last_dr : r[10:8];
    kind = (r[21:20] == 2'b10) ? 2'b11 : r[21:20];
    sel = first + int'(r[31:16]) % kinds;

    case (sel)
        0: word = opr_word(`LC3B_OP_ADD, dr, sr1, 1'b0, {2'b00, sr2});
        1: word = opr_word(`LC3B_OP_ADD, dr, sr1, 1'b1, r[26:22]);
        2: word = opr_word(`LC3B_OP_AND, dr, sr1, 1'b0, {2'b00, sr2});
        3: word = opr_word(`LC3B_OP_AND, dr, sr1, 1'b1, r[26:22]);
        4: word = opr_word(`LC3B_OP_NOT, dr, sr1, 1'b1, 5'b11111);
        5: word = opr_word(`LC3B_OP_SHF, dr, sr1, kind[1], {kind[0], r[25:22]});
        6: word = lea_word(dr, r[30:22]);
        7:
        begin
            addr = model_reg[sr1] + {{9{r[27]}}, r[27:22], 1'b0};
            if (model_mem_ok[addr[`LC3B_DMEM_AW:1]])
                word = mem_word(`LC3B_OP_LDR, dr, sr1, r[27:22]);
            else
                word = mem_word(`LC3B_OP_STR, sr2, sr1, r[27:22]);  // nothing stored there yet
        end
        default: word = mem_word(`LC3B_OP_STR, sr2, sr1, r[27:22]);
    endcase
    return word;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// driving and checking

task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected)
    begin
        $display("[FAIL] %s expected %h actual %h", what, expected, actual);
        error_count++;
    end
endtask

task automatic issue_instr(input logic [15:0] word);
    instr_valid <= 1'b1;
    instr <= word;
    @(posedge clk);
    while (ready_sampled !== 1'b1)
        @(posedge clk);
    model_execute(word);                        // accepted on this edge
    issue_count++;
endtask

task automatic issue_random(input int count, input int first, input int kinds);
    logic [2:0] last_dr;
    logic [15:0] word;

    last_dr = 3'd0;
    for (int i = 0; i < count; i++)
    begin
        word = random_instr(last_dr, first, kinds);
        issue_instr(word);
        last_dr = word[11:9];                   // half the time the next one reads it
    end
endtask

task automatic start_test(input string name);
    test_name = name;
    errors_at_start = error_count;
    commits_at_start = commit_count;
    issues_at_start = issue_count;
endtask

task automatic finish_test();
    int waited;

    instr_valid <= 1'b0;
    waited = 0;
    while (expect_q.size() != 0 && waited < DRAIN_LIMIT)
    begin
        @(posedge clk);
        waited++;
    end
    if (expect_q.size() != 0)
    begin
        $display("%s: %0d expected register writes never came out of the pipeline",
                 test_name, expect_q.size());
        error_count++;
        expect_q.delete();
    end
    test_count++;
    $display("test %s: %0d instructions, %0d commits, %0d errors", test_name,
             issue_count - issues_at_start, commit_count - commits_at_start,
             error_count - errors_at_start);
endtask

always @(negedge clk)
    ready_sampled <= instr_ready;

always @(negedge clk)
begin
    logic [21:0] expected;

    if (!rst && wb_valid === 1'b1)
    begin
        commit_count++;
        if (expect_q.size() == 0)
        begin
            $display("%s: commit to r%0d with data %h arrived with no write pending",
                     test_name, wb_dr, wb_data);
            error_count++;
        end
        else
        begin
            expected = expect_q.pop_front();
            check_value({test_name, " wb_dr"}, expected[21:19], wb_dr);
            check_value({test_name, " wb_data"}, expected[18:3], wb_data);
            check_value({test_name, " wb_cc"}, expected[2:0], wb_cc);
        end
    end
end

always @(posedge clk)
begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT)
    begin
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Regression failed");
        $finish;
    end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stimulus

initial
begin
    logic [31:0] r;
    logic [5:0] off;
    logic [15:0] addr;

    rst = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    clear_model();
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // registers start at zero, so seed each one with an immediate first
    start_test("alu");
    for (int i = 0; i < `LC3B_NREG; i++)
    begin
        r = xorshift();
        issue_instr(opr_word(`LC3B_OP_ADD, 3'(i), 3'(i), 1'b1, r[4:0]));
    end
    issue_random(N_ALU - `LC3B_NREG, 0, 5);
    finish_test();

    start_test("shf");
    issue_random(N_SHF, 5, 1);
    finish_test();

    // the codes enter the LEA run as z and no LEA result near the PC is zero
    start_test("lea");
    issue_instr(opr_word(`LC3B_OP_AND, 3'd0, 3'd0, 1'b1, 5'd0));
    issue_random(N_LEA - 1, 6, 1);
    finish_test();

    start_test("str_ldr");
    for (int i = 0; i < N_LDST / 2; i++)
    begin
        r = xorshift();
        issue_instr(mem_word(`LC3B_OP_STR, r[2:0], r[5:3], r[14:9]));
        issue_instr(mem_word(`LC3B_OP_LDR, r[8:6], r[5:3], r[14:9]));
    end
    finish_test();

    // r6 is the pointer, r5 the base of the pointer word, r4 the data
    start_test("sti_ldi");
    for (int i = 0; i < N_IND / 6; i++)
    begin
        r = xorshift();
        issue_instr(opr_word(`LC3B_OP_ADD, 3'd4, 3'd4, 1'b1, r[4:0]));
        issue_instr(lea_word(3'd6, r[13:5]));
        off = r[19:14];
        addr = model_reg[5] + {{9{off[5]}}, off, 1'b0};
        while (addr[`LC3B_DMEM_AW:1] == model_reg[6][`LC3B_DMEM_AW:1])
        begin
            off = off + 6'd1;                   // pointer word must not be its own target
            addr = model_reg[5] + {{9{off[5]}}, off, 1'b0};
        end
        issue_instr(mem_word(`LC3B_OP_STR, 3'd6, 3'd5, off));
        issue_instr(mem_word(`LC3B_OP_STI, 3'd4, 3'd5, off));
        issue_instr(mem_word(`LC3B_OP_LDI, 3'd3, 3'd5, off));
        issue_instr(mem_word(`LC3B_OP_LDR, 3'd2, 3'd6, 6'd0));
    end
    finish_test();

    start_test("random");
    issue_random(N_RAND, 0, 9);
    finish_test();

    $display("%0d tests, %0d instructions, %0d commits checked, %0d errors",
             test_count, issue_count, commit_count, error_count);
    if (error_count == 0)
        $display("Regression passed");
    else
        $display("Regression failed");
    $finish;
end

endmodule : lc3b_core_tb

// File: compile.f
+incdir+rtl
rtl/lc3b_pkg.sv
rtl/lc3b_regfile.sv
rtl/lc3b_decode.sv
rtl/lc3b_execute.sv
rtl/lc3b_mem_stage.sv
rtl/lc3b_core.sv
verif/lc3b_core_tb.sv

// File: Bender.yml
package:
  name: lc3b_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lc3b_pkg.sv
      - rtl/lc3b_regfile.sv
      - rtl/lc3b_decode.sv
      - rtl/lc3b_execute.sv
      - rtl/lc3b_mem_stage.sv
      - rtl/lc3b_core.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/lc3b_core_tb.sv
